/* control_fsm.sv */
`default_nettype none
`timescale 1ns/10ps

module control_fsm (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire cpu_pkg::decoded_t    dec,
    input  wire cpu_pkg::status_t     status,
    output cpu_pkg::dp_ctrl_t         dp_ctrl,
    output cpu_pkg::fetch_ctrl_t      fetch_ctrl,
    output cpu_pkg::mem_cmd_t         mem_cmd,
    output logic                      halt
);
    import cpu_pkg::*;

    // s_a..s_h are the execute steps, kept in order
    typedef enum logic [3:0] {
        s_rst, s_if1, s_if2, s_update, s_decode,
        s_a, s_b, s_c, s_d, s_e, s_f, s_g, s_h,
        s_halt
    } state_t;

    localparam logic [1:0] mov_reg_op = 2'b00;
    localparam logic [1:0] mov_imm_op = 2'b10;

    state_t       state;
    state_t       state_nxt;
    state_t       last_state;
    branch_cond_t cond;
    logic         cond_ok;
    logic         taken;
    logic         mov_imm;
    dp_ctrl_t     dp_nxt;
    fetch_ctrl_t  fc_nxt;
    mem_cmd_t     cmd_nxt;

    assign mov_imm = (dec.op == mov_imm_op);
    assign cond    = branch_cond_t'(dec.rn);
    assign cond_ok = (dec.rn <= 3'd4);

    always_comb
    begin
        case (cond)
            cond_always: taken = 1'b1;
            cond_eq:     taken = status.z;
            cond_ne:     taken = !status.z;
            cond_lt:     taken = (status.n != status.v);
            cond_le:     taken = (status.n != status.v) || status.z;
            default:     taken = 1'b0;
        endcase
    end

    // final execute step per instruction
    always_comb
    begin
        case (dec.opcode)
            op_mov:    last_state = mov_imm ? s_a : s_c;
            op_alu:    last_state = s_d;
            op_ldr:    last_state = s_f;
            op_str:    last_state = s_h;
            op_branch: last_state = s_b;
            default:   last_state = s_a;
        endcase
    end

    always_comb
    begin
        case (state)
            s_rst:    state_nxt = s_if1;
            s_if1:    state_nxt = s_if2;
            s_if2:    state_nxt = s_update;
            s_update: state_nxt = s_decode;
            s_decode:
            begin
                case (dec.opcode)
                    op_mov:
                        state_nxt = (mov_imm || dec.op == mov_reg_op) ? s_a : s_halt;
                    op_branch: state_nxt = cond_ok ? s_a : s_halt;
                    op_halt:   state_nxt = s_halt;
                    default:   state_nxt = s_a;
                endcase
            end
            s_halt:   state_nxt = s_halt;  // only reset leaves
            default:
                state_nxt = (state == last_state) ? s_if1 : state_t'(state + 4'd1);
        endcase
    end

    // controls for the state being entered
    always_comb
    begin
        dp_nxt  = '0;
        fc_nxt  = '0;
        cmd_nxt = mem_none;
        case (state_nxt)
            s_if1:
            begin
                cmd_nxt        = mem_read;
                fc_nxt.addr_pc = 1'b1;
            end
            s_if2:
            begin
                cmd_nxt        = mem_read;
                fc_nxt.addr_pc = 1'b1;
                fc_nxt.load_ir = 1'b1;
            end
            s_update: fc_nxt.load_pc = 1'b1;
            s_a:
            begin
                case (dec.opcode)
                    op_mov:
                    begin
                        if (mov_imm)
                        begin
                            dp_nxt.wb_sel = wb_imm8;
                            dp_nxt.write  = 1'b1;
                        end
                        else
                        begin
                            dp_nxt.reg_sel = sel_rm;
                            dp_nxt.load_b  = 1'b1;
                        end
                    end
                    op_alu, op_ldr, op_str: dp_nxt.load_a = 1'b1;  // rn
                    default: ;
                endcase
            end
            s_b:
            begin
                case (dec.opcode)
                    op_mov:
                    begin
                        dp_nxt.a_zero = 1'b1;
                        dp_nxt.load_c = 1'b1;
                    end
                    op_alu:
                    begin
                        dp_nxt.reg_sel = sel_rm;
                        dp_nxt.load_b  = 1'b1;
                    end
                    op_branch:
                    begin
                        fc_nxt.load_pc   = taken;
                        fc_nxt.pc_branch = taken;
                    end
                    default: ;
                endcase
            end
            s_c:
            begin
                case (dec.opcode)
                    op_mov:
                    begin
                        dp_nxt.reg_sel = sel_rd;
                        dp_nxt.write   = 1'b1;
                    end
                    op_alu:
                    begin
                        dp_nxt.alu_op = alu_op_t'(dec.op);
                        dp_nxt.load_s = (dp_nxt.alu_op == alu_cmp);
                        dp_nxt.load_c = (dp_nxt.alu_op != alu_cmp);
                    end
                    op_ldr, op_str:
                    begin
                        dp_nxt.b_imm  = 1'b1;  // base + imm5
                        dp_nxt.load_c = 1'b1;
                    end
                    default: ;
                endcase
            end
            s_d:
            begin
                if (dec.opcode == op_alu)
                begin
                    dp_nxt.reg_sel = sel_rd;
                    dp_nxt.write   = (alu_op_t'(dec.op) != alu_cmp);
                end
                else
                    fc_nxt.load_addr = 1'b1;
            end
            s_e:
            begin
                if (dec.opcode == op_ldr)
                    cmd_nxt = mem_read;
            end
            s_f:
            begin
                dp_nxt.reg_sel = sel_rd;
                if (dec.opcode == op_ldr)
                begin
                    cmd_nxt       = mem_read;
                    dp_nxt.wb_sel = wb_mem_data;
                    dp_nxt.write  = 1'b1;
                end
                else
                    dp_nxt.load_b = 1'b1;  // store data
            end
            s_g:
            begin
                dp_nxt.a_zero = 1'b1;
                dp_nxt.load_c = 1'b1;
            end
            s_h: cmd_nxt = mem_write;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= s_rst;
            dp_ctrl    <= '0;
            fetch_ctrl <= '0;
            mem_cmd    <= mem_none;
            halt       <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            dp_ctrl    <= dp_nxt;
            fetch_ctrl <= fc_nxt;
            mem_cmd    <= cmd_nxt;
            halt       <= (state_nxt == s_halt);
        end
    end

endmodule

`default_nettype wire

/* cpu.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`CPU_WORD_W-1:0] read_data,
    output logic [`CPU_WORD_W-1:0]      out,
    output cpu_pkg::status_t            status,
    output cpu_pkg::mem_cmd_t           mem_cmd,
    output logic [`CPU_ADDR_W-1:0]      mem_addr,
    output logic                        halt
);
    import cpu_pkg::*;

    logic [`CPU_WORD_W-1:0] instr;
    decoded_t               dec;
    dp_ctrl_t               dp_ctrl;
    fetch_ctrl_t            fetch_ctrl;

    instr_decode i_decode (
        .instr (instr),
        .dec   (dec)
    );

    fetch_unit i_fetch (
        .clk       (clk),
        .reset     (reset),
        .read_data (read_data),
        .ctrl      (fetch_ctrl),
        .dec       (dec),
        .c_value   (out),
        .mem_addr  (mem_addr),
        .instr     (instr)
    );

    control_fsm i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .status     (status),
        .dp_ctrl    (dp_ctrl),
        .fetch_ctrl (fetch_ctrl),
        .mem_cmd    (mem_cmd),
        .halt       (halt)
    );

    // C doubles as store data
    datapath i_dp (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (dp_ctrl),
        .dec     (dec),
        .mdata   (read_data),
        .c_value (out),
        .status  (status)
    );

endmodule

`default_nettype wire

/* cpu_checker.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_checker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire cpu_pkg::mem_cmd_t      mem_cmd,
    input  wire logic [`CPU_ADDR_W-1:0] mem_addr,
    input  wire logic [`CPU_WORD_W-1:0] out,
    input  wire cpu_pkg::status_t       status,
    input  wire logic                   halt,
    output int                          errors
);
    import cpu_pkg::*;

    string                  test_name;
    logic [`CPU_ADDR_W-1:0] exp_addr;
    logic [`CPU_WORD_W-1:0] exp_val;
    status_t                exp_flags;
    logic                   saw_store;
    logic [`CPU_ADDR_W-1:0] st_addr;
    logic [`CPU_WORD_W-1:0] st_val;
    int                     check_errs = 0;
    int                     watch_errs = 0;
    int                     watch_start;
    int                     check_start;
    int                     reset_cycles = 0;
    int                     passed = 0;
    int                     failed = 0;

    assign errors = check_errs + watch_errs;

    // bus watcher, samples values from before the edge
    always @(posedge clk)
    begin
        if (reset)
        begin
            if (reset_cycles > 0 && (mem_cmd != mem_none || halt))
            begin
                $display("test %s: memory command or halt active during reset", test_name);
                watch_errs++;
            end
            reset_cycles++;
            saw_store = 1'b0;
        end
        else
        begin
            reset_cycles = 0;
            if (halt && mem_cmd != mem_none)
            begin
                $display("test %s: memory access after halt", test_name);
                watch_errs++;
            end
            if (mem_cmd == mem_write)
            begin
                saw_store = 1'b1;
                st_addr   = mem_addr;
                st_val    = out;
            end
        end
    end

    task automatic begin_test(input string name, input logic [`CPU_ADDR_W-1:0] addr,
                              input logic [`CPU_WORD_W-1:0] val, input status_t flags);
        test_name   = name;
        exp_addr    = addr;
        exp_val     = val;
        exp_flags   = flags;
        watch_start = watch_errs;
        check_start = check_errs;
    endtask

    task automatic end_test();
        int n;
        if (!saw_store)
        begin
            $display("test %s: no store was seen before halt", test_name);
            check_errs++;
        end
        else
        begin
            if (st_addr !== exp_addr)
            begin
                $display("Error %s store address: expected %h, actual %h",
                         test_name, exp_addr, st_addr);
                check_errs++;
            end
            if (st_val !== exp_val)
            begin
                $display("Error %s store value: expected %h, actual %h",
                         test_name, exp_val, st_val);
                check_errs++;
            end
        end
        if (status !== exp_flags)   // nvz
        begin
            $display("Error %s flags: expected %b, actual %b", test_name, exp_flags, status);
            check_errs++;
        end
        n = (check_errs - check_start) + (watch_errs - watch_start);
        if (n == 0)
        begin
            $display("test %s: pass", test_name);
            passed++;
        end
        else
        begin
            $display("test %s: fail with %0d errors", test_name, n);
            failed++;
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
    endtask

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    // instr[15:13]
    typedef enum logic [2:0] {
        op_branch = 3'b001,
        op_ldr    = 3'b011,
        op_str    = 3'b100,
        op_alu    = 3'b101,
        op_mov    = 3'b110,
        op_halt   = 3'b111
    } opcode_t;

    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        sh_none         = 2'b00,
        sh_left1        = 2'b01,
        sh_right_logic1 = 2'b10,
        sh_right_arith1 = 2'b11
    } shift_t;

    // sits in the rn field of a branch
    typedef enum logic [2:0] {
        cond_always = 3'b000,
        cond_eq     = 3'b001,
        cond_ne     = 3'b010,
        cond_lt     = 3'b011,
        cond_le     = 3'b100
    } branch_cond_t;

    typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_t;

    typedef enum logic [1:0] {wb_c_reg, wb_imm8, wb_mem_data} wb_sel_t;

    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_read  = 2'b01,
        mem_write = 2'b11
    } mem_cmd_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
    } status_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [1:0]                op;      // alu op, or mov variant
        logic [`CPU_REG_IDX_W-1:0] rn;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [`CPU_REG_IDX_W-1:0] rm;
        shift_t                    shift;
        logic [`CPU_WORD_W-1:0]    imm8;
        logic [`CPU_WORD_W-1:0]    imm5;
        logic [`CPU_ADDR_W-1:0]    br_off;
    } decoded_t;

    typedef struct packed {
        reg_sel_t reg_sel;
        wb_sel_t  wb_sel;
        alu_op_t  alu_op;
        logic     write;
        logic     load_a;
        logic     load_b;
        logic     load_c;
        logic     load_s;
        logic     a_zero;
        logic     b_imm;
    } dp_ctrl_t;

    typedef struct packed {
        logic load_ir;
        logic load_pc;
        logic pc_branch;
        logic load_addr;
        logic addr_pc;
    } fetch_ctrl_t;

endpackage

`default_nettype wire

/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and instruction word
`define CPU_WORD_W 16

// word addressed memory, also the PC width
`define CPU_ADDR_W 9

// general register file
`define CPU_REG_COUNT 8
`define CPU_REG_IDX_W 3

// first fetch after reset
`define CPU_RESET_PC 0

`endif

/* datapath.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_settings.svh"

module datapath (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire cpu_pkg::dp_ctrl_t      ctrl,
    input  wire cpu_pkg::decoded_t      dec,
    input  wire logic [`CPU_WORD_W-1:0] mdata,
    output logic [`CPU_WORD_W-1:0]      c_value,
    output cpu_pkg::status_t            status
);
    import cpu_pkg::*;

    logic [`CPU_WORD_W-1:0]    regs [`CPU_REG_COUNT];
    logic [`CPU_REG_IDX_W-1:0] idx;
    logic [`CPU_WORD_W-1:0]    rd_val;
    logic [`CPU_WORD_W-1:0]    wb_val;
    logic [`CPU_WORD_W-1:0]    a_reg;
    logic [`CPU_WORD_W-1:0]    b_reg;
    logic [`CPU_WORD_W-1:0]    b_sh;
    logic [`CPU_WORD_W-1:0]    ain;
    logic [`CPU_WORD_W-1:0]    bin;
    logic [`CPU_WORD_W-1:0]    result;
    logic                      ovf;

    // one index for both read and write
    always_comb
    begin
        case (ctrl.reg_sel)
            sel_rn:  idx = dec.rn;
            sel_rd:  idx = dec.rd;
            default: idx = dec.rm;
        endcase
    end

    assign rd_val = regs[idx];

    always_comb
    begin
        case (ctrl.wb_sel)
            wb_imm8:     wb_val = dec.imm8;
            wb_mem_data: wb_val = mdata;
            default:     wb_val = c_value;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.write)
            regs[idx] <= wb_val;
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_a)
            a_reg <= rd_val;
        if (ctrl.load_b)
            b_reg <= rd_val;
    end

    always_comb
    begin
        case (dec.shift)
            sh_left1:        b_sh = {b_reg[`CPU_WORD_W-2:0], 1'b0};
            sh_right_logic1: b_sh = {1'b0, b_reg[`CPU_WORD_W-1:1]};
            sh_right_arith1: b_sh = {b_reg[`CPU_WORD_W-1], b_reg[`CPU_WORD_W-1:1]};
            default:         b_sh = b_reg;
        endcase
    end

    assign ain = ctrl.a_zero ? '0 : a_reg;
    assign bin = ctrl.b_imm ? dec.imm5 : b_sh;

    always_comb
    begin
        case (ctrl.alu_op)
            alu_add: result = ain + bin;
            alu_cmp: result = ain - bin;
            alu_and: result = ain & bin;
            default: result = ~bin;  // mvn
        endcase
    end

    // signed overflow of ain - bin
    assign ovf = (ain[`CPU_WORD_W-1] ^ bin[`CPU_WORD_W-1])
               & (result[`CPU_WORD_W-1] ^ ain[`CPU_WORD_W-1]);

    always_ff @(posedge clk)
    begin
        if (ctrl.load_c)
            c_value <= result;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            status <= '0;
        else if (ctrl.load_s)
        begin
            status.n <= result[`CPU_WORD_W-1];
            status.v <= ovf;
            status.z <= (result == '0);
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_settings.svh"

module fetch_unit (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`CPU_WORD_W-1:0] read_data,
    input  wire cpu_pkg::fetch_ctrl_t   ctrl,
    input  wire cpu_pkg::decoded_t      dec,
    input  wire logic [`CPU_WORD_W-1:0] c_value,
    output logic [`CPU_ADDR_W-1:0]      mem_addr,
    output logic [`CPU_WORD_W-1:0]      instr
);

    localparam logic [`CPU_ADDR_W-1:0] reset_pc = `CPU_RESET_PC;

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] next_pc;
    logic [`CPU_ADDR_W-1:0] data_addr;

    // instruction register
    always_ff @(posedge clk)
    begin
        if (ctrl.load_ir)
            instr <= read_data;
    end

    // pc already holds branch address + 1 by the time a branch executes
    assign next_pc = ctrl.pc_branch ? pc + dec.br_off : pc + 1'b1;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= reset_pc;
        else if (ctrl.load_pc)
            pc <= next_pc;
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_addr)
            data_addr <= c_value[`CPU_ADDR_W-1:0];  // base + imm5 from C
    end

    assign mem_addr = ctrl.addr_pc ? pc : data_addr;

endmodule

`default_nettype wire

/* instr_decode.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_settings.svh"

module instr_decode (
    input  wire logic [`CPU_WORD_W-1:0] instr,
    output cpu_pkg::decoded_t           dec
);
    import cpu_pkg::*;

    logic [2:0] raw_op;

    assign raw_op = instr[15:13];

    always_comb
    begin
        // call group and unused codes fall through to halt
        if (raw_op inside {op_mov, op_alu, op_ldr, op_str, op_branch})
            dec.opcode = opcode_t'(raw_op);
        else
            dec.opcode = op_halt;

        dec.op = instr[12:11];
        dec.rn = instr[10:8];
        dec.rd = instr[7:5];
        dec.rm = instr[2:0];

        // imm5 sits on the shift bits of ldr/str
        if (raw_op inside {op_ldr, op_str})
            dec.shift = sh_none;
        else
            dec.shift = shift_t'(instr[4:3]);

        dec.imm8   = {{(`CPU_WORD_W - 8){instr[7]}}, instr[7:0]};
        dec.imm5   = {{(`CPU_WORD_W - 5){instr[4]}}, instr[4:0]};
        dec.br_off = {{(`CPU_ADDR_W - 8){instr[7]}}, instr[7:0]};
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
# build and run with Verilator, fail if the log holds the fail message
verilator --binary --timing --top-module tb_cpu -f tb.f -o tb_cpu_sim > build.log 2>&1 &&
./obj_dir/tb_cpu_sim > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

/* tb.f */
+incdir+.
cpu_pkg.sv
instr_decode.sv
fetch_unit.sv
control_fsm.sv
datapath.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

/* tb_cpu.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu_settings.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int num_tests   = 19;
    localparam int prog_words  = 12;
    localparam int mem_words   = 512;
    localparam int watchdog_ns = num_tests * prog_words * 11 * 8 + num_tests * 5 * 8;

    typedef struct packed {
        logic [prog_words-1:0][`CPU_WORD_W-1:0] prog;
        logic [`CPU_WORD_W-1:0]                 data;     // lands at address 100
        logic [`CPU_ADDR_W-1:0]                 st_addr;
        logic [`CPU_WORD_W-1:0]                 st_val;
        status_t                                flags;
    } test_t;

    logic                   clk;
    logic                   reset;
    logic [`CPU_WORD_W-1:0] read_data;
    logic [`CPU_WORD_W-1:0] out;
    status_t                status;
    mem_cmd_t               mem_cmd;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic                   halt;
    int                     errors;

    logic [`CPU_WORD_W-1:0] mem [mem_words];
    test_t                  tests [num_tests];
    string                  names [num_tests];
    int                     n_rows = 0;
    logic [`CPU_WORD_W-1:0] prog_q [$];

    always #4 clk = ~clk;

    cpu i_cpu (
        .clk       (clk),
        .reset     (reset),
        .read_data (read_data),
        .out       (out),
        .status    (status),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .halt      (halt)
    );

    cpu_checker i_chk (
        .clk      (clk),
        .reset    (reset),
        .mem_cmd  (mem_cmd),
        .mem_addr (mem_addr),
        .out      (out),
        .status   (status),
        .halt     (halt),
        .errors   (errors)
    );

    // memory is always ready
    assign read_data = mem[mem_addr];

    always @(posedge clk)
    begin
        if (mem_cmd == mem_write)
            mem[mem_addr] <= out;
    end

    function automatic logic [15:0] mov_imm(input logic [2:0] rn, input logic [7:0] imm);
        return {op_mov, 2'b10, rn, imm};
    endfunction

    function automatic logic [15:0] mov_reg(input logic [2:0] rd, input logic [2:0] rm,
                                            input shift_t sh);
        return {op_mov, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function automatic logic [15:0] alu_word(input alu_op_t op, input logic [2:0] rd,
                                             input logic [2:0] rn, input logic [2:0] rm,
                                             input shift_t sh);
        return {op_alu, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [15:0] load_word(input logic [2:0] rd, input logic [2:0] rn,
                                              input logic [4:0] off);
        return {op_ldr, 2'b00, rn, rd, off};
    endfunction

    function automatic logic [15:0] store_word(input logic [2:0] rd, input logic [2:0] rn,
                                               input logic [4:0] off);
        return {op_str, 2'b00, rn, rd, off};
    endfunction

    function automatic logic [15:0] branch_word(input branch_cond_t c, input logic [7:0] off);
        return {op_branch, 2'b00, c, off};
    endfunction

    function automatic logic [15:0] shift_b(input logic [15:0] v, input shift_t sh);
        case (sh)
            sh_left1:        return v << 1;
            sh_right_logic1: return v >> 1;
            sh_right_arith1: return $signed(v) >>> 1;
            default:         return v;
        endcase
    endfunction

    function automatic status_t cmp_flags(input logic [15:0] a, input logic [15:0] b);
        int      diff;
        status_t f;
        diff = int'($signed(a)) - int'($signed(b));   // exact signed difference
        f.n  = diff[15];
        f.z  = (diff[15:0] == 16'h0000);
        f.v  = (diff > 32767) || (diff < -32768);
        return f;
    endfunction

    function automatic logic cond_taken(input branch_cond_t c, input status_t f);
        case (c)
            cond_eq: return f.z;
            cond_ne: return !f.z;
            cond_lt: return f.n != f.v;
            cond_le: return (f.n != f.v) || f.z;
            default: return 1'b1;
        endcase
    endfunction

    // program comes from prog_q and the rest of the row is halt
    task automatic add_row(input string name, input logic [15:0] data,
                           input logic [8:0] addr, input logic [15:0] val,
                           input status_t flags);
        test_t row;
        row.prog = {prog_words{16'he000}};
        for (int i = 0; i < prog_q.size(); i++)
            row.prog[i] = prog_q[i];
        row.data    = data;
        row.st_addr = addr;
        row.st_val  = val;
        row.flags   = flags;
        tests[n_rows] = row;
        names[n_rows] = name;
        n_rows++;
        prog_q.delete();
    endtask

    // marker 0x22 when taken and 0x11 when the branch falls through
    task automatic add_branch_row(input string name, input branch_cond_t c,
                                  input logic [7:0] a8, input logic [7:0] b8);
        status_t f;
        f = cmp_flags({{8{a8[7]}}, a8}, {{8{b8[7]}}, b8});
        prog_q = {mov_imm(3'd1, a8), mov_imm(3'd2, b8),
                  alu_word(alu_cmp, 3'd0, 3'd1, 3'd2, sh_none),
                  mov_imm(3'd4, 8'd120), mov_imm(3'd3, 8'h22),
                  branch_word(c, 8'd1), mov_imm(3'd3, 8'h11),
                  store_word(3'd3, 3'd4, 5'd2), 16'he000};
        add_row(name, 16'($urandom), 9'd122, cond_taken(c, f) ? 16'h0022 : 16'h0011, f);
    endtask

    task automatic add_load_row(input string name, input logic [7:0] base,
                                input logic [4:0] ld_off, input logic [7:0] k,
                                input logic [4:0] st_off);
        logic [15:0] data;
        data   = 16'($urandom);
        prog_q = {mov_imm(3'd1, base), load_word(3'd2, 3'd1, ld_off),
                  mov_imm(3'd3, k), alu_word(alu_add, 3'd2, 3'd2, 3'd3, sh_none),
                  store_word(3'd2, 3'd1, st_off), 16'he000};
        add_row(name, data, {1'b0, base} + {{4{st_off[4]}}, st_off},
                data + {{8{k[7]}}, k}, 3'b000);
    endtask

    task automatic build_table();
        status_t ovf_flags;
        prog_q = {mov_imm(3'd1, 8'd120), mov_imm(3'd2, 8'h25),
                  store_word(3'd2, 3'd1, 5'h1c), 16'he000};          // offset -4
        add_row("mov_imm_pos", 16'($urandom), 9'd116, 16'h0025, 3'b000);
        prog_q = {mov_imm(3'd1, 8'd90), mov_imm(3'd2, 8'hb3),
                  store_word(3'd2, 3'd1, 5'h10), 16'he000};          // offset -16
        add_row("mov_imm_neg", 16'($urandom), 9'd74, 16'hffb3, 3'b000);
        prog_q = {mov_imm(3'd1, 8'h35), mov_imm(3'd2, 8'hfd),
                  alu_word(alu_add, 3'd3, 3'd1, 3'd2, sh_left1),
                  mov_imm(3'd4, 8'd120), store_word(3'd3, 3'd4, 5'd0), 16'he000};
        add_row("add_lsl", 16'($urandom), 9'd120,
                16'h0035 + shift_b(16'hfffd, sh_left1), 3'b000);
        prog_q = {mov_imm(3'd1, 8'h7f), mov_imm(3'd2, 8'h7f),
                  alu_word(alu_add, 3'd3, 3'd1, 3'd2, sh_none),
                  mov_imm(3'd4, 8'd120), store_word(3'd3, 3'd4, 5'd3), 16'he000};
        add_row("add_none", 16'($urandom), 9'd123, 16'h007f + 16'h007f, 3'b000);
        prog_q = {mov_imm(3'd1, 8'hff), mov_imm(3'd2, 8'h80),
                  alu_word(alu_and, 3'd3, 3'd1, 3'd2, sh_right_logic1),
                  mov_imm(3'd4, 8'd121), store_word(3'd3, 3'd4, 5'd0), 16'he000};
        add_row("and_lsr", 16'($urandom), 9'd121,
                16'hffff & shift_b(16'hff80, sh_right_logic1), 3'b000);
        prog_q = {mov_imm(3'd1, 8'h5a), mov_imm(3'd2, 8'ha6),
                  alu_word(alu_and, 3'd3, 3'd1, 3'd2, sh_right_arith1),
                  mov_imm(3'd4, 8'd121), store_word(3'd3, 3'd4, 5'd1), 16'he000};
        add_row("and_asr", 16'($urandom), 9'd122,
                16'h005a & shift_b(16'hffa6, sh_right_arith1), 3'b000);
        prog_q = {mov_imm(3'd2, 8'h9c),
                  alu_word(alu_mvn, 3'd3, 3'd0, 3'd2, sh_right_arith1),
                  mov_imm(3'd4, 8'd122), store_word(3'd3, 3'd4, 5'd0), 16'he000};
        add_row("mvn_asr", 16'($urandom), 9'd122, ~shift_b(16'hff9c, sh_right_arith1), 3'b000);
        prog_q = {mov_imm(3'd2, 8'hfb), mov_reg(3'd3, 3'd2, sh_left1),
                  mov_imm(3'd4, 8'd123), store_word(3'd3, 3'd4, 5'd0), 16'he000};
        add_row("mov_reg_lsl", 16'($urandom), 9'd123, shift_b(16'hfffb, sh_left1), 3'b000);
        add_branch_row("beq_taken", cond_eq, 8'd5, 8'd5);
        add_branch_row("beq_not", cond_eq, 8'd5, 8'd6);
        add_branch_row("bne_taken", cond_ne, 8'd3, 8'd7);
        add_branch_row("bne_not", cond_ne, 8'd7, 8'd7);
        add_branch_row("blt_taken", cond_lt, 8'hfc, 8'd3);
        add_branch_row("blt_not", cond_lt, 8'd9, 8'd2);
        add_branch_row("ble_equal", cond_le, 8'd4, 8'd4);
        add_branch_row("ble_not", cond_le, 8'd6, 8'hfe);
        add_branch_row("b_always", cond_always, 8'd1, 8'd2);
        // 0x8000 - 1 overflows, so lt rests on v
        ovf_flags = cmp_flags(16'h8000, 16'h0001);
        prog_q = {mov_imm(3'd5, 8'd100), load_word(3'd1, 3'd5, 5'd0),
                  mov_imm(3'd2, 8'd1), alu_word(alu_cmp, 3'd0, 3'd1, 3'd2, sh_none),
                  mov_imm(3'd4, 8'd120), mov_imm(3'd3, 8'h22),
                  branch_word(cond_lt, 8'd1), mov_imm(3'd3, 8'h11),
                  store_word(3'd3, 3'd4, 5'd2), 16'he000};
        add_row("blt_overflow", 16'h8000, 9'd122,
                cond_taken(cond_lt, ovf_flags) ? 16'h0022 : 16'h0011, ovf_flags);
        add_load_row("ldr_add_str", 8'd100, 5'd0, 8'd45, 5'h1e);
    endtask

    task automatic run_test(input int t);
        @(negedge clk);
        reset = 1'b1;
        for (int a = 0; a < mem_words; a++)
            mem[a] = 16'he000 | 16'(a);          // halt fill with the address in the low bits
        for (int i = 0; i < prog_words; i++)
            mem[i] = tests[t].prog[i];
        mem[100] = tests[t].data;
        i_chk.begin_test(names[t], tests[t].st_addr, tests[t].st_val, tests[t].flags);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        while (!halt)
            @(negedge clk);
        repeat (3) @(negedge clk);   // watch for stray accesses
        i_chk.end_test();
    endtask

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the DUT did not reach halt in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        void'($urandom(32'hb13d763f));
        build_table();
        for (int t = 0; t < n_rows; t++)
            run_test(t);
        i_chk.report_counts();
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
